// File: dispatch_params.svh
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// Architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5
`define XLEN 32

// Cycles from issue to write-back, MUL has to be the longest pipe
`define LAT_ALU 1
`define LAT_LSU 2
`define LAT_MUL 3

// Forward the write-back value to same-cycle reads (0 turns it off)
`define ENABLE_BYPASS_WB 1

`endif

// File: dispatch_pkg.sv
package dispatch_pkg;

    // Target execution pipe, one-hot
    typedef enum logic [3:0] {
        PIPE_NONE = 4'b0000,
        PIPE_ALU  = 4'b0001,
        PIPE_LSU  = 4'b0010,
        PIPE_MUL  = 4'b0100,
        PIPE_DIV  = 4'b1000
    } exe_pipe_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } branch_op_e;

    typedef enum logic [1:0] {
        MUL_MUL,
        MUL_MULH,
        MUL_MULHSU,
        MUL_MULHU
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } div_op_e;

endpackage

// File: operand_fetch.sv
`include "dispatch_params.svh"

module operand_fetch (
    input  logic                   clk,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    input  logic [`REG_ADDR_W-1:0] a1,
    input  logic [`REG_ADDR_W-1:0] a2,
    input  logic [`REG_ADDR_W-1:0] rd,
    output logic [`XLEN-1:0]       rs1_val,
    output logic [`XLEN-1:0]       rs2_val,
    output logic                   fwd_rs1,
    output logic                   fwd_rs2,
    output logic                   fwd_rd
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wb_live;
    logic             wb_fwd;

    // Writes to x0 are dropped
    assign wb_live = wb_en && (wb_rd != '0);
    assign wb_fwd  = (`ENABLE_BYPASS_WB != 0) && wb_live;

    always_ff @(posedge clk) begin
        if (wb_live) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Bypass hits also go to the scoreboard
    assign fwd_rs1 = wb_fwd && (wb_rd == a1);
    assign fwd_rs2 = wb_fwd && (wb_rd == a2);
    assign fwd_rd  = wb_fwd && (wb_rd == rd);

    // x0 reads zero whatever the array holds
    always_comb begin
        if (a1 == '0) begin
            rs1_val = '0;
        end else if (fwd_rs1) begin
            rs1_val = wb_data;
        end else begin
            rs1_val = regs[a1];
        end
    end

    always_comb begin
        if (a2 == '0) begin
            rs2_val = '0;
        end else if (fwd_rs2) begin
            rs2_val = wb_data;
        end else begin
            rs2_val = regs[a2];
        end
    end

    // Stored and forwarded paths give the same value one cycle apart
    a_rs1_after_wb: assert property (@(posedge clk)
        (wb_live && (wb_rd == a1)) ##1 ($stable(a1) && !fwd_rs1)
        |-> rs1_val == $past(wb_data));

    a_rs2_after_wb: assert property (@(posedge clk)
        (wb_live && (wb_rd == a2)) ##1 ($stable(a2) && !fwd_rs2)
        |-> rs2_val == $past(wb_data));

endmodule

// File: hazard_tracker.sv
`include "dispatch_params.svh"

module hazard_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_fire,
    input  dispatch_pkg::exe_pipe_e pipe,
    input  logic [`REG_ADDR_W-1:0] a1,
    input  logic [`REG_ADDR_W-1:0] a2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   reg_write,
    input  logic                   fwd_rs1,
    input  logic                   fwd_rs2,
    input  logic                   fwd_rd,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic                   flush,
    input  logic                   div_done,
    output logic                   sb_conflict,
    output logic                   wb_conflict,
    output logic                   div_stall
);

    import dispatch_pkg::*;

    logic [`NUM_REGS-1:0] pending;
    logic [`NUM_REGS-1:0] set_bits;
    logic [`NUM_REGS-1:0] clr_bits;
    // mul_slot[j] means a MUL writes back j+1 cycles from now
    logic [`LAT_MUL-2:0]  mul_slot;
    logic                 mul_issue;
    logic                 div_issue;

    assign mul_issue = issue_fire && (pipe == PIPE_MUL);
    assign div_issue = issue_fire && (pipe == PIPE_DIV);

    always_comb begin
        set_bits = '0;
        clr_bits = '0;
        // x0 is never marked pending
        if (issue_fire && reg_write && (rd != '0)) begin
            set_bits[rd] = 1'b1;
        end
        if (wb_en) begin
            clr_bits[wb_rd] = 1'b1;
        end
    end

    // A new destination wins over a write-back to the same index
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_bits) | set_bits;
        end
    end

    assign sb_conflict = (pending[a1] && !fwd_rs1)
                      || (pending[a2] && !fwd_rs2)
                      || (pending[rd] && !fwd_rd);

    // Countdown of MUL write-back slots
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_slot <= '0;
        end else begin
            mul_slot <= {mul_issue, mul_slot[`LAT_MUL-2:1]};
        end
    end

    // Shorter pipes must not land on a slot already taken by a MUL
    always_comb begin
        case (pipe)
            PIPE_ALU: wb_conflict = mul_slot[`LAT_ALU-1];
            PIPE_LSU: wb_conflict = mul_slot[`LAT_LSU-1];
            default:  wb_conflict = 1'b0;
        endcase
    end

    // Busy while the serial divider runs
    always_ff @(posedge clk) begin
        if (rst || flush || div_done) begin
            div_stall <= 1'b0;
        end else if (div_issue) begin
            div_stall <= 1'b1;
        end
    end

    a_sb_set_sticks: assert property (@(posedge clk) disable iff (rst)
        (issue_fire && reg_write && (rd != '0)) |=> pending[$past(rd)]);

    a_div_stall_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(div_stall) |-> $past(div_issue));

endmodule

// File: issue_stage.sv
`include "dispatch_params.svh"

module issue_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       flush,
    input  logic                       flush_div,
    input  logic                       id_valid,
    input  dispatch_pkg::exe_pipe_e    id_pipe,
    input  logic [`REG_ADDR_W-1:0]     id_a1,
    input  logic [`REG_ADDR_W-1:0]     id_a2,
    input  logic [`REG_ADDR_W-1:0]     id_rd,
    input  logic                       id_reg_write,
    input  logic                       id_alu_src,
    input  logic [`XLEN-1:0]           id_imm,
    input  logic [`XLEN-1:0]           id_pc,
    input  logic [`XLEN-1:0]           id_pc_inc,
    input  logic                       id_jal,
    input  logic                       id_jalr,
    input  logic                       id_branch,
    input  dispatch_pkg::branch_op_e   id_branch_op,
    input  dispatch_pkg::alu_op_e      id_alu_op,
    input  logic                       id_result_src,
    input  logic                       id_mem_load,
    input  logic                       id_mem_store,
    input  dispatch_pkg::mul_op_e      id_mul_op,
    input  dispatch_pkg::div_op_e      id_div_op,
    input  logic [`XLEN-1:0]           rs1_val,
    input  logic [`XLEN-1:0]           rs2_val,
    input  logic                       sb_conflict,
    input  logic                       wb_conflict,
    output logic                       issue_fire,
    output logic                       dispatch_conflict,
    output logic                       alu_valid,
    output logic [`REG_ADDR_W-1:0]     alu_rd,
    output logic                       alu_reg_write,
    output logic [`XLEN-1:0]           alu_rs1,
    output logic [`XLEN-1:0]           alu_rs2,
    output logic [`XLEN-1:0]           alu_imm,
    output logic [`XLEN-1:0]           alu_pc,
    output logic [`XLEN-1:0]           alu_pc_inc,
    output logic [`XLEN-1:0]           alu_pc_base,
    output logic                       alu_branch,
    output logic                       alu_jump,
    output dispatch_pkg::branch_op_e   alu_branch_op,
    output dispatch_pkg::alu_op_e      alu_op,
    output logic                       alu_result_src,
    output logic                       lsu_valid,
    output logic [`REG_ADDR_W-1:0]     lsu_rd,
    output logic                       lsu_reg_write,
    output logic [`XLEN-1:0]           lsu_rs1,
    output logic [`XLEN-1:0]           lsu_imm,
    output logic [`XLEN-1:0]           lsu_wdata,
    output logic                       lsu_load,
    output logic                       lsu_store,
    output logic                       mul_valid,
    output logic [`REG_ADDR_W-1:0]     mul_rd,
    output logic [`XLEN-1:0]           mul_rs1,
    output logic [`XLEN-1:0]           mul_rs2,
    output dispatch_pkg::mul_op_e      mul_op,
    output logic                       div_valid,
    output logic [`REG_ADDR_W-1:0]     div_rd,
    output logic [`XLEN-1:0]           div_rs1,
    output logic [`XLEN-1:0]           div_rs2,
    output dispatch_pkg::div_op_e      div_op
);

    import dispatch_pkg::*;

    logic alu_fire;
    logic lsu_fire;
    logic mul_fire;
    logic div_fire;

    // A conflicting instruction stays at the ID inputs
    assign issue_fire        = id_valid && !stall && !flush && !sb_conflict && !wb_conflict;
    assign dispatch_conflict = id_valid && (sb_conflict || wb_conflict);

    assign alu_fire = issue_fire && (id_pipe == PIPE_ALU);
    assign lsu_fire = issue_fire && (id_pipe == PIPE_LSU);
    assign mul_fire = issue_fire && (id_pipe == PIPE_MUL);
    assign div_fire = issue_fire && (id_pipe == PIPE_DIV);

    // ALU, LSU and MUL controls share the main flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_valid      <= 1'b0;
            alu_reg_write  <= 1'b0;
            alu_branch     <= 1'b0;
            alu_jump       <= 1'b0;
            alu_branch_op  <= BR_BEQ;
            alu_op         <= ALU_ADD;
            alu_result_src <= 1'b0;
            lsu_valid      <= 1'b0;
            lsu_reg_write  <= 1'b0;
            lsu_load       <= 1'b0;
            lsu_store      <= 1'b0;
            mul_valid      <= 1'b0;
            mul_op         <= MUL_MUL;
        end else if (!stall) begin
            alu_valid <= alu_fire;
            lsu_valid <= lsu_fire;
            mul_valid <= mul_fire;
            if (alu_fire) begin
                alu_reg_write  <= id_reg_write;
                alu_branch     <= id_branch;
                alu_jump       <= id_jal || id_jalr;
                alu_branch_op  <= id_branch_op;
                alu_op         <= id_alu_op;
                alu_result_src <= id_result_src;
            end
            if (lsu_fire) begin
                lsu_reg_write <= id_reg_write;
                lsu_load      <= id_mem_load;
                lsu_store     <= id_mem_store;
            end
            if (mul_fire) begin
                mul_op <= id_mul_op;
            end
        end
    end

    // The divider has its own flush
    always_ff @(posedge clk) begin
        if (rst || flush_div) begin
            div_valid <= 1'b0;
            div_op    <= DIV_DIV;
        end else if (!stall) begin
            div_valid <= div_fire;
            if (div_fire) begin
                div_op <= id_div_op;
            end
        end
    end

    // Payload, loaded only for the pipe that takes the instruction
    always_ff @(posedge clk) begin
        if (alu_fire) begin
            alu_rd      <= id_rd;
            alu_rs1     <= rs1_val;
            // Immediate baked into rs2 for register-immediate ops
            alu_rs2     <= id_alu_src ? id_imm : rs2_val;
            alu_imm     <= id_imm;
            alu_pc      <= id_pc;
            alu_pc_inc  <= id_pc_inc;
            alu_pc_base <= id_jalr ? rs1_val : id_pc;
        end
        if (lsu_fire) begin
            lsu_rd    <= id_rd;
            lsu_rs1   <= rs1_val;
            lsu_imm   <= id_imm;
            lsu_wdata <= rs2_val;
        end
        if (mul_fire) begin
            mul_rd  <= id_rd;
            mul_rs1 <= rs1_val;
            mul_rs2 <= rs2_val;
        end
        if (div_fire) begin
            div_rd  <= id_rd;
            div_rs1 <= rs1_val;
            div_rs2 <= rs2_val;
        end
    end

    a_one_valid: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_valid, lsu_valid, mul_valid, div_valid}));

    // Stall would hold an older valid, so only the unstalled case is checked
    a_conflict_blocks: assert property (@(posedge clk) disable iff (rst)
        (dispatch_conflict && !stall)
        |=> !(alu_valid || lsu_valid || mul_valid || div_valid));

endmodule

// File: dispatch_top.sv
`include "dispatch_params.svh"

module dispatch_top (
    input  logic                       clk,
    input  logic                       rst,
    // ID side, held until issue
    input  logic                       id_valid,
    input  dispatch_pkg::exe_pipe_e    id_pipe,
    input  logic [`REG_ADDR_W-1:0]     id_a1, id_a2, id_rd,
    input  logic                       id_reg_write, id_alu_src,
    input  logic [`XLEN-1:0]           id_imm, id_pc, id_pc_inc,
    input  logic                       id_jal, id_jalr, id_branch,
    input  dispatch_pkg::branch_op_e   id_branch_op,
    input  dispatch_pkg::alu_op_e      id_alu_op,
    input  logic                       id_result_src, id_mem_load, id_mem_store,
    input  dispatch_pkg::mul_op_e      id_mul_op,
    input  dispatch_pkg::div_op_e      id_div_op,
    // Write-back port
    input  logic                       wb_en,
    input  logic [`REG_ADDR_W-1:0]     wb_rd,
    input  logic [`XLEN-1:0]           wb_data,
    // Core control
    input  logic                       stall, flush, flush_div, div_done,
    output logic                       dispatch_conflict, div_stall,
    // ALU pipe
    output logic                       alu_valid,
    output logic [`REG_ADDR_W-1:0]     alu_rd,
    output logic                       alu_reg_write,
    output logic [`XLEN-1:0]           alu_rs1, alu_rs2, alu_imm,
    output logic [`XLEN-1:0]           alu_pc, alu_pc_inc, alu_pc_base,
    output logic                       alu_branch, alu_jump,
    output dispatch_pkg::branch_op_e   alu_branch_op,
    output dispatch_pkg::alu_op_e      alu_op,
    output logic                       alu_result_src,
    // LSU pipe
    output logic                       lsu_valid,
    output logic [`REG_ADDR_W-1:0]     lsu_rd,
    output logic                       lsu_reg_write,
    output logic [`XLEN-1:0]           lsu_rs1, lsu_imm, lsu_wdata,
    output logic                       lsu_load, lsu_store,
    // MUL pipe
    output logic                       mul_valid,
    output logic [`REG_ADDR_W-1:0]     mul_rd,
    output logic [`XLEN-1:0]           mul_rs1, mul_rs2,
    output dispatch_pkg::mul_op_e      mul_op,
    // DIV pipe
    output logic                       div_valid,
    output logic [`REG_ADDR_W-1:0]     div_rd,
    output logic [`XLEN-1:0]           div_rs1, div_rs2,
    output dispatch_pkg::div_op_e      div_op
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             fwd_rs1;
    logic             fwd_rs2;
    logic             fwd_rd;
    logic             sb_conflict;
    logic             wb_conflict;
    logic             issue_fire;

    operand_fetch u_operand_fetch (
        .a1 (id_a1),
        .a2 (id_a2),
        .rd (id_rd),
        .*
    );

    hazard_tracker u_hazard_tracker (
        .pipe      (id_pipe),
        .a1        (id_a1),
        .a2        (id_a2),
        .rd        (id_rd),
        .reg_write (id_reg_write),
        .*
    );

    // Port names match the top level one to one
    issue_stage u_issue_stage (
        .*
    );

endmodule

// File: tb_dispatch_top.sv
`include "dispatch_params.svh"

module tb_dispatch_top;
    timeunit 1ns;
    timeprecision 1ps;
    import dispatch_pkg::*;

    localparam int N_DIR = 12;
    localparam int N_RAND = 300;
    localparam int CYC_BUDGET = 40;

    logic clk = 1'b0, rst = 1'b1;
    logic id_valid = 1'b0, id_reg_write = 1'b0, id_alu_src = 1'b0, id_jal = 1'b0;
    logic id_jalr = 1'b0, id_branch = 1'b0, id_result_src = 1'b0;
    logic id_mem_load = 1'b0, id_mem_store = 1'b0;
    exe_pipe_e id_pipe = PIPE_NONE;
    logic [`REG_ADDR_W-1:0] id_a1 = '0, id_a2 = '0, id_rd = '0, wb_rd = '0;
    logic [`XLEN-1:0] id_imm = '0, id_pc = '0, id_pc_inc = '0, wb_data = '0;
    branch_op_e id_branch_op = BR_BEQ;
    alu_op_e id_alu_op = ALU_ADD;
    mul_op_e id_mul_op = MUL_MUL;
    div_op_e id_div_op = DIV_DIV;
    logic wb_en = 1'b0, stall = 1'b0, flush = 1'b0, flush_div = 1'b0, div_done = 1'b0;
    logic dispatch_conflict, div_stall, alu_valid, alu_reg_write, alu_branch, alu_jump;
    logic alu_result_src, lsu_valid, lsu_reg_write, lsu_load, lsu_store, mul_valid, div_valid;
    logic [`REG_ADDR_W-1:0] alu_rd, lsu_rd, mul_rd, div_rd;
    logic [`XLEN-1:0] alu_rs1, alu_rs2, alu_imm, alu_pc, alu_pc_inc, alu_pc_base;
    logic [`XLEN-1:0] lsu_rs1, lsu_imm, lsu_wdata, mul_rs1, mul_rs2, div_rs1, div_rs2;
    branch_op_e alu_branch_op;
    alu_op_e alu_op;
    mul_op_e mul_op;
    div_op_e div_op;

    // Reference model state
    integer seed = 32'h2ca8_b9b4;
    integer init_idx = 1, val_errs = 0, other_errs = 0;
    logic [`XLEN-1:0] m_regs [`NUM_REGS];
    logic [`NUM_REGS-1:0] m_pend = '0;
    logic [`LAT_MUL-1:0] mh = '0;
    logic [3:0] exp_valid = '0;
    logic exp_div_stall = 1'b0, div_busy = 1'b0, rst_q = 1'b0, rand_stall = 1'b0;
    logic [207:0] exp_alu;
    logic [103:0] exp_lsu;
    logic [70:0] exp_mul, exp_div;
    // Write-back schedule where index 0 is driven in the coming cycle
    logic slot_v [32], slot_done [32];
    logic [`REG_ADDR_W-1:0] slot_rd [32];

    dispatch_top DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [`XLEN-1:0] op_val(input logic [`REG_ADDR_W-1:0] idx);
        if (idx == '0) return '0;
        if (`ENABLE_BYPASS_WB != 0 && wb_en && wb_rd == idx) return wb_data;
        return m_regs[idx];
    endfunction

    // Registers still pending once a forwarded write-back is taken out
    wire [`NUM_REGS-1:0] fwd_mask = (`ENABLE_BYPASS_WB != 0 && wb_en)
                                    ? ({{(`NUM_REGS-1){1'b0}}, 1'b1} << wb_rd) : '0;
    wire [`NUM_REGS-1:0] live_pend = m_pend & ~fwd_mask;

    // MUL issued k+1 cycles ago sits in mh[k]
    wire exp_wbc = (id_pipe == PIPE_ALU && mh[`LAT_MUL-`LAT_ALU-1])
                || (id_pipe == PIPE_LSU && mh[`LAT_MUL-`LAT_LSU-1]);
    wire exp_sb = live_pend[id_a1] || live_pend[id_a2] || live_pend[id_rd];
    wire exp_conf = id_valid && (exp_sb || exp_wbc);
    wire exp_fire = id_valid && !stall && !flush && !exp_sb && !exp_wbc;
    wire [5:0] dut_stat = {div_valid, mul_valid, lsu_valid, alu_valid, dispatch_conflict,
                           div_stall};
    wire [5:0] exp_stat = {exp_valid, exp_conf, exp_div_stall};
    wire [207:0] dut_alu = {alu_rd, alu_reg_write, alu_rs1, alu_rs2, alu_imm, alu_pc,
                            alu_pc_inc, alu_pc_base, alu_branch, alu_jump, alu_branch_op,
                            alu_op, alu_result_src};
    wire [103:0] dut_lsu = {lsu_rd, lsu_reg_write, lsu_rs1, lsu_imm, lsu_wdata, lsu_load,
                            lsu_store};
    wire [70:0] dut_mul = {mul_rd, mul_rs1, mul_rs2, mul_op};
    wire [70:0] dut_div = {div_rd, div_rs1, div_rs2, div_op};

    task automatic report(input string name, input logic [207:0] e, input logic [207:0] a);
        val_errs++;
        $display("ERR t=%0t %s expected %h actual %h", $time, name, e, a);
    endtask

    a_reset_quiet: assert property (@(posedge clk) rst_q |-> dut_stat == '0)
        else begin
            other_errs++;
            $display("Outputs not quiet after reset at t=%0t", $time);
        end
    a_status: assert property (@(posedge clk) disable iff (rst) dut_stat == exp_stat)
        else report("valids_conflict_div_stall", $sampled(exp_stat), $sampled(dut_stat));
    a_alu: assert property (@(posedge clk) disable iff (rst) alu_valid |-> dut_alu == exp_alu)
        else report("alu_bundle", $sampled(exp_alu), $sampled(dut_alu));
    a_lsu: assert property (@(posedge clk) disable iff (rst) lsu_valid |-> dut_lsu == exp_lsu)
        else report("lsu_bundle", $sampled(exp_lsu), $sampled(dut_lsu));
    a_mul: assert property (@(posedge clk) disable iff (rst) mul_valid |-> dut_mul == exp_mul)
        else report("mul_bundle", $sampled(exp_mul), $sampled(dut_mul));
    a_div: assert property (@(posedge clk) disable iff (rst) div_valid |-> dut_div == exp_div)
        else report("div_bundle", $sampled(exp_div), $sampled(dut_div));

    // Plays write-back and the divider after first filling every register once
    always @(negedge clk) begin
        if (!rst && init_idx < `NUM_REGS) begin
            wb_en = 1'b1;
            wb_rd = init_idx[`REG_ADDR_W-1:0];
            div_done = 1'b0;
            init_idx++;
        end else begin
            wb_en = slot_v[0];
            wb_rd = slot_rd[0];
            div_done = slot_done[0];
        end
        wb_data = $random(seed);
    end

    always @(posedge clk) begin
        logic [`NUM_REGS-1:0] nxt;
        int k;
        nxt = m_pend;
        if (wb_en) nxt[wb_rd] = 1'b0;
        if (exp_fire && id_reg_write && id_rd != '0) nxt[id_rd] = 1'b1;
        if (wb_en && wb_rd != '0) m_regs[wb_rd] <= wb_data;
        rst_q <= rst;
        for (int i = 0; i < 31; i++) begin
            slot_v[i] = slot_v[i+1];
            slot_rd[i] = slot_rd[i+1];
            slot_done[i] = slot_done[i+1];
        end
        slot_v[31] = 1'b0;
        slot_done[31] = 1'b0;
        if (rst) begin
            m_pend <= '0;
            mh <= '0;
            exp_valid <= '0;
            exp_div_stall <= 1'b0;
            div_busy <= 1'b0;
        end else begin
            m_pend <= nxt;
            mh <= {mh[`LAT_MUL-2:0], exp_fire && id_pipe == PIPE_MUL};
            if (flush) exp_valid[2:0] <= '0;
            else if (!stall) exp_valid[2:0] <= exp_fire ? id_pipe[2:0] : 3'b000;
            if (flush_div) exp_valid[3] <= 1'b0;
            else if (!stall) exp_valid[3] <= exp_fire && id_pipe == PIPE_DIV;
            if (flush || div_done) exp_div_stall <= 1'b0;
            else if (exp_fire && id_pipe == PIPE_DIV) exp_div_stall <= 1'b1;
            if (div_done) div_busy <= 1'b0;
            if (exp_fire) begin
                case (id_pipe)
                    PIPE_ALU: begin
                        k = `LAT_ALU - 1;
                        exp_alu <= {id_rd, id_reg_write, op_val(id_a1),
                                    id_alu_src ? id_imm : op_val(id_a2), id_imm, id_pc,
                                    id_pc_inc, id_jalr ? op_val(id_a1) : id_pc, id_branch,
                                    id_jal || id_jalr, id_branch_op, id_alu_op, id_result_src};
                    end
                    PIPE_LSU: begin
                        k = `LAT_LSU - 1;
                        exp_lsu <= {id_rd, id_reg_write, op_val(id_a1), id_imm,
                                    op_val(id_a2), id_mem_load, id_mem_store};
                    end
                    PIPE_MUL: begin
                        k = `LAT_MUL - 1;
                        exp_mul <= {id_rd, op_val(id_a1), op_val(id_a2), id_mul_op};
                    end
                    default: begin
                        k = 2 + ($unsigned($random(seed)) % 5);
                        slot_done[k] = 1'b1;
                        div_busy <= 1'b1;
                        exp_div <= {id_rd, op_val(id_a1), op_val(id_a2), id_div_op};
                    end
                endcase
                if (id_reg_write && id_rd != '0) begin
                    while (slot_v[k]) k++;
                    slot_v[k] = 1'b1;
                    slot_rd[k] = id_rd;
                end
            end
        end
    end

    // Called at a falling edge and returns at the falling edge after issue
    task automatic offer(input exe_pipe_e p, input int a1, input int a2, input int rd,
                         input logic rw);
        logic fired;
        id_valid = 1'b1;
        id_pipe = p;
        id_a1 = a1;
        id_a2 = a2;
        id_rd = rd;
        id_reg_write = rw;
        {id_alu_src, id_jal, id_jalr, id_branch, id_result_src} = $random(seed);
        {id_mem_load, id_mem_store} = $random(seed);
        id_imm = $random(seed);
        id_pc = $random(seed);
        id_pc_inc = id_pc + 4;
        id_branch_op = branch_op_e'($unsigned($random(seed)) % 6);
        id_alu_op = alu_op_e'($unsigned($random(seed)) % 10);
        id_mul_op = mul_op_e'($random(seed));
        id_div_op = div_op_e'($random(seed));
        do begin
            @(posedge clk);
            fired = exp_fire;
            @(negedge clk);
            stall = !fired && rand_stall && ($unsigned($random(seed)) % 5 == 0);
        end while (!fired);
        id_valid = 1'b0;
    endtask

    task automatic random_instr();
        exe_pipe_e p;
        p = exe_pipe_e'(4'b0001 << ($unsigned($random(seed)) % (div_busy ? 3 : 4)));
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        offer(p, $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8,
              $unsigned($random(seed)) % 8, $random(seed));
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            slot_v[i] = 1'b0;
            slot_done[i] = 1'b0;
            slot_rd[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (init_idx == `NUM_REGS);
        @(negedge clk);
        offer(PIPE_ALU, 1, 2, 5, 1'b1);
        offer(PIPE_LSU, 3, 4, 7, 1'b1);
        offer(PIPE_ALU, 7, 0, 6, 1'b1);
        offer(PIPE_ALU, 0, 0, 0, 1'b1);
        offer(PIPE_MUL, 1, 2, 8, 1'b1);
        offer(PIPE_LSU, 3, 4, 11, 1'b1);
        offer(PIPE_MUL, 1, 2, 9, 1'b1);
        @(negedge clk);
        offer(PIPE_ALU, 3, 4, 12, 1'b1);
        // Flush with stall held keeps div_valid and flush_div then drops it
        offer(PIPE_DIV, 1, 2, 10, 1'b1);
        stall = 1'b1;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        flush_div = 1'b1;
        @(negedge clk);
        flush_div = 1'b0;
        stall = 1'b0;
        offer(PIPE_ALU, 1, 3, 0, 1'b0);
        stall = 1'b1;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        stall = 1'b0;
        wait (!div_busy);
        @(negedge clk);
        offer(PIPE_DIV, 4, 5, 13, 1'b1);
        rand_stall = 1'b1;
        repeat (N_RAND) random_instr();
        rand_stall = 1'b0;
        repeat (20) @(negedge clk);
        $display("Value errors %0d, other errors %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((N_DIR + N_RAND) * CYC_BUDGET * 4);
        $display("Watchdog expired before all instructions issued");
        $display("Value errors %0d, other errors %0d", val_errs, other_errs);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
dispatch_pkg.sv
operand_fetch.sv
hazard_tracker.sv
issue_stage.sv
dispatch_top.sv
tb_dispatch_top.sv
